/* hdl/l2_geom_pkg.sv */
`default_nettype none

package l2_geom_pkg;

    // Cache organisation
    localparam int N_WAYS   = 4;
    localparam int N_SETS   = 16;
    localparam int N_CORES  = 4;
    localparam int BEATS    = 8;   // 64-bit beats per 64-byte line

    // Address split
    localparam int OFFSET_W = 6;
    localparam int SET_W    = 4;
    localparam int TAG_W    = 54;  // 64 - SET_W - OFFSET_W

    // Requester identification
    localparam int SOURCE_W = 6;
    localparam int CID_W    = 2;   // Top bits of the source

    typedef logic [63:0] addr_t;
    typedef logic [63:0] data_t;

    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [SET_W-1:0] set_t;

    typedef logic [1:0]        way_t;
    typedef logic [N_WAYS-1:0] way_mask_t;

    // Directory record fields
    typedef logic [N_CORES-1:0] core_mask_t;
    typedef logic [CID_W-1:0]   core_id_t;

    typedef logic [SOURCE_W-1:0] source_t;
    typedef logic [2:0]          beat_t;

endpackage

`default_nettype wire

/* hdl/l2_tl_pkg.sv */
`default_nettype none

package l2_tl_pkg;

    typedef logic [2:0] opcode_t;
    typedef logic [2:0] param_t;   // Grow parameter on A
    typedef logic [1:0] cap_t;     // Capability parameter on D

    // A channel opcodes
    localparam opcode_t A_ACQUIRE_BLOCK = 3'd6;
    localparam opcode_t A_ACQUIRE_PERM  = 3'd7;

    // D channel opcodes
    localparam opcode_t D_GRANT         = 3'd4;
    localparam opcode_t D_GRANT_DATA    = 3'd5;

    // Permission growth requested by the core
    localparam param_t GROW_NTOB = 3'd0;
    localparam param_t GROW_NTOT = 3'd1;
    localparam param_t GROW_BTOT = 3'd2;

    // Permission handed back with the grant
    localparam cap_t CAP_TOT = 2'd0;
    localparam cap_t CAP_TOB = 2'd1;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MEM_REQ,
        MEM_FILL,
        GRANT,
        UPDATE
    } l2_state_e;

endpackage

`default_nettype wire

/* hdl/l2_way_match.sv */
`default_nettype none

module l2_way_match (
    input  wire                       clk_i,
    input  wire                       rst_ni,
    input  l2_geom_pkg::set_t         set_i,
    input  l2_geom_pkg::tag_t         tag_i,
    input  wire                       we_i,
    input  l2_geom_pkg::core_mask_t   wr_sharers_i,
    input  wire                       wr_owner_valid_i,
    input  l2_geom_pkg::core_id_t     wr_owner_id_i,
    output logic                      valid_o,
    output logic                      match_o,
    output l2_geom_pkg::core_mask_t   sharers_o,
    output logic                      owner_valid_o,
    output l2_geom_pkg::core_id_t     owner_id_o
);

    import l2_geom_pkg::*;

    logic       valid_q [N_SETS];
    tag_t       tag_q [N_SETS];
    core_mask_t sharers_q [N_SETS];
    logic       owner_valid_q [N_SETS];
    core_id_t   owner_id_q [N_SETS];

    // Valid bits are the only per-set state cleared by reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int s = 0; s < N_SETS; s++) begin
                valid_q[s] <= 1'b0;
            end
        end else if (we_i) begin
            valid_q[set_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            tag_q[set_i]         <= tag_i;
            sharers_q[set_i]     <= wr_sharers_i;
            owner_valid_q[set_i] <= wr_owner_valid_i;
            owner_id_q[set_i]    <= wr_owner_id_i;
        end
    end

    assign valid_o       = valid_q[set_i];
    assign match_o       = valid_q[set_i] && (tag_q[set_i] == tag_i);
    assign sharers_o     = sharers_q[set_i];
    assign owner_valid_o = owner_valid_q[set_i];
    assign owner_id_o    = owner_id_q[set_i];

endmodule

`default_nettype wire

/* hdl/l2_hit_select.sv */
`default_nettype none

module l2_hit_select (
    input  wire                                                  clk_i,
    input  wire                                                  rst_ni,
    input  l2_geom_pkg::set_t                                    set_i,
    input  l2_geom_pkg::way_mask_t                               valid_i,
    input  l2_geom_pkg::way_mask_t                               match_i,
    input  l2_geom_pkg::core_mask_t [l2_geom_pkg::N_WAYS-1:0]    sharers_i,
    input  l2_geom_pkg::way_mask_t                               owner_valid_i,
    input  l2_geom_pkg::core_id_t [l2_geom_pkg::N_WAYS-1:0]      owner_id_i,
    input  wire                                                  touch_i,
    input  l2_geom_pkg::way_t                                    touch_way_i,
    output logic                                                 hit_o,
    output l2_geom_pkg::way_t                                    hit_way_o,
    output l2_geom_pkg::core_mask_t                              hit_sharers_o,
    output logic                                                 hit_owner_valid_o,
    output l2_geom_pkg::core_id_t                                hit_owner_id_o,
    output l2_geom_pkg::way_t                                    victim_way_o
);

    import l2_geom_pkg::*;

    // Tree bits per set: [0] root, [1] ways 0/1, [2] ways 2/3
    logic [2:0] plru_q [N_SETS];
    logic [2:0] plru_cur;
    way_t       plru_way;

    always_comb begin
        hit_o             = 1'b0;
        hit_way_o         = '0;
        hit_sharers_o     = '0;
        hit_owner_valid_o = 1'b0;
        hit_owner_id_o    = '0;
        for (int w = 0; w < N_WAYS; w++) begin
            if (match_i[w]) begin
                hit_o             = 1'b1;
                hit_way_o         = way_t'(w);
                hit_sharers_o     = sharers_i[w];
                hit_owner_valid_o = owner_valid_i[w];
                hit_owner_id_o    = owner_id_i[w];
            end
        end
    end

    assign plru_cur = plru_q[set_i];
    assign plru_way = plru_cur[0] ? {1'b1, plru_cur[2]} : {1'b0, plru_cur[1]};

    // Fill empty ways first, lowest index wins
    always_comb begin
        victim_way_o = plru_way;
        for (int w = N_WAYS - 1; w >= 0; w--) begin
            if (!valid_i[w]) begin
                victim_way_o = way_t'(w);
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int s = 0; s < N_SETS; s++) begin
                plru_q[s] <= 3'b000;
            end
        end else if (touch_i) begin
            plru_q[set_i][0] <= ~touch_way_i[1];  // Root points to the other half
            if (touch_way_i[1]) begin
                plru_q[set_i][2] <= ~touch_way_i[0];
            end else begin
                plru_q[set_i][1] <= ~touch_way_i[0];
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/l2_data_array.sv */
`default_nettype none

module l2_data_array (
    input  wire                  clk_i,
    input  l2_geom_pkg::way_t    way_i,
    input  l2_geom_pkg::set_t    set_i,
    input  l2_geom_pkg::beat_t   beat_i,
    input  wire                  we_i,
    input  l2_geom_pkg::data_t   wdata_i,
    output l2_geom_pkg::data_t   rdata_o
);

    import l2_geom_pkg::*;

    // One word per beat of every line
    data_t mem_q [N_WAYS][N_SETS][BEATS];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem_q[way_i][set_i][beat_i] <= wdata_i;
        end
    end

    assign rdata_o = mem_q[way_i][set_i][beat_i];  // Async read for grant beats

endmodule

`default_nettype wire

/* hdl/l2_ctrl.sv */
`default_nettype none

module l2_ctrl (
    input  wire                       clk_i,
    input  wire                       rst_ni,
    // A channel
    input  l2_tl_pkg::opcode_t        a_opcode_i,
    input  l2_tl_pkg::param_t         a_param_i,
    input  l2_geom_pkg::source_t      a_source_i,
    input  l2_geom_pkg::addr_t        a_address_i,
    input  wire                       a_valid_i,
    output logic                      a_ready_o,
    // D channel
    output l2_tl_pkg::opcode_t        d_opcode_o,
    output l2_tl_pkg::cap_t           d_param_o,
    output l2_geom_pkg::source_t      d_source_o,
    output l2_geom_pkg::data_t        d_data_o,
    output logic                      d_valid_o,
    input  wire                       d_ready_i,
    // Memory
    output l2_geom_pkg::addr_t        mem_a_address_o,
    output logic                      mem_a_valid_o,
    input  wire                       mem_a_ready_i,
    input  l2_geom_pkg::data_t        mem_d_data_i,
    input  wire                       mem_d_valid_i,
    output logic                      mem_d_ready_o,
    // Lookup
    output l2_geom_pkg::set_t         set_o,
    output l2_geom_pkg::tag_t         tag_o,
    input  wire                       hit_i,
    input  l2_geom_pkg::way_t         hit_way_i,
    input  l2_geom_pkg::core_mask_t   hit_sharers_i,
    input  wire                       hit_owner_valid_i,
    input  l2_geom_pkg::core_id_t     hit_owner_id_i,
    input  l2_geom_pkg::way_t         victim_way_i,
    // Directory write
    output l2_geom_pkg::way_mask_t    dir_we_o,
    output l2_geom_pkg::core_mask_t   dir_sharers_o,
    output logic                      dir_owner_valid_o,
    output l2_geom_pkg::core_id_t     dir_owner_id_o,
    // PLRU
    output logic                      touch_o,
    output l2_geom_pkg::way_t         touch_way_o,
    // Data array
    output l2_geom_pkg::way_t         data_way_o,
    output l2_geom_pkg::beat_t        data_beat_o,
    output logic                      data_we_o,
    output l2_geom_pkg::data_t        data_wdata_o,
    input  l2_geom_pkg::data_t        data_rdata_i
);

    import l2_geom_pkg::*;
    import l2_tl_pkg::*;

    localparam beat_t LAST_BEAT = beat_t'(BEATS - 1);

    l2_state_e state_q, state_d;
    beat_t     beat_q;

    // Request and lookup result, held for the whole transaction
    opcode_t    req_opcode_q;
    param_t     req_param_q;
    source_t    req_source_q;
    addr_t      req_addr_q;
    logic       hit_q;
    way_t       way_q;          // Hit way or refill victim
    core_mask_t hit_sharers_q;
    logic       hit_owner_valid_q;
    core_id_t   hit_owner_id_q;

    core_id_t req_cid;
    logic     grant_data;
    logic     shared_grow;      // NtoB keeps other sharers
    logic     grant_last;

    assign req_cid    = req_source_q[SOURCE_W-1 -: CID_W];
    assign grant_data = (req_opcode_q == A_ACQUIRE_BLOCK);
    assign grant_last = !grant_data || (beat_q == LAST_BEAT);

    always_comb begin
        case (req_param_q)
            GROW_NTOB:            shared_grow = grant_data;
            GROW_NTOT, GROW_BTOT: shared_grow = 1'b0;
            default:              shared_grow = 1'b0;
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:     if (a_valid_i) state_d = LOOKUP;
            LOOKUP:   state_d = hit_i ? GRANT : MEM_REQ;
            MEM_REQ:  if (mem_a_ready_i) state_d = MEM_FILL;
            MEM_FILL: if (mem_d_valid_i && beat_q == LAST_BEAT) state_d = GRANT;
            GRANT:    if (d_ready_i && grant_last) state_d = UPDATE;
            UPDATE:   state_d = IDLE;
            default:  state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            beat_q  <= '0;
            hit_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == LOOKUP) begin
                hit_q <= hit_i;
            end
            // Counter wraps back to zero after a full line
            if (state_q == MEM_FILL && mem_d_valid_i) begin
                beat_q <= beat_q + beat_t'(1);
            end else if (state_q == GRANT && d_ready_i && grant_data) begin
                beat_q <= beat_q + beat_t'(1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && a_valid_i) begin
            req_opcode_q <= a_opcode_i;
            req_param_q  <= a_param_i;
            req_source_q <= a_source_i;
            req_addr_q   <= a_address_i;
        end
        if (state_q == LOOKUP) begin
            way_q             <= hit_i ? hit_way_i : victim_way_i;
            hit_sharers_q     <= hit_sharers_i;
            hit_owner_valid_q <= hit_owner_valid_i;
            hit_owner_id_q    <= hit_owner_id_i;
        end
    end

    assign a_ready_o = (state_q == IDLE);

    assign set_o = req_addr_q[OFFSET_W +: SET_W];
    assign tag_o = req_addr_q[63 -: TAG_W];

    // Single line-aligned Get
    assign mem_a_valid_o   = (state_q == MEM_REQ);
    assign mem_a_address_o = {req_addr_q[63:OFFSET_W], {OFFSET_W{1'b0}}};
    assign mem_d_ready_o   = (state_q == MEM_FILL);

    assign data_way_o   = way_q;
    assign data_beat_o  = beat_q;
    assign data_we_o    = (state_q == MEM_FILL) && mem_d_valid_i;
    assign data_wdata_o = mem_d_data_i;

    assign d_valid_o  = (state_q == GRANT);
    assign d_opcode_o = grant_data ? D_GRANT_DATA : D_GRANT;
    assign d_param_o  = shared_grow ? CAP_TOB : CAP_TOT;
    assign d_source_o = req_source_q;
    assign d_data_o   = grant_data ? data_rdata_i : '0;

    // New directory record, a refilled line starts from an empty entry
    always_comb begin
        if (shared_grow) begin
            dir_sharers_o     = (hit_q ? hit_sharers_q : '0) | (core_mask_t'(1) << req_cid);
            dir_owner_valid_o = hit_q && hit_owner_valid_q;
            dir_owner_id_o    = hit_q ? hit_owner_id_q : '0;
        end else begin
            dir_sharers_o     = core_mask_t'(1) << req_cid;
            dir_owner_valid_o = 1'b1;
            dir_owner_id_o    = req_cid;
        end
    end

    assign dir_we_o    = (state_q == UPDATE) ? (way_mask_t'(1) << way_q) : '0;
    assign touch_o     = (state_q == UPDATE);
    assign touch_way_o = way_q;

endmodule

`default_nettype wire

/* hdl/l2_top.sv */
`default_nettype none

module l2_top (
    input  wire                    clk_i,
    input  wire                    rst_ni,
    input  l2_tl_pkg::opcode_t     a_opcode_i,
    input  l2_tl_pkg::param_t      a_param_i,
    input  l2_geom_pkg::source_t   a_source_i,
    input  l2_geom_pkg::addr_t     a_address_i,
    input  wire                    a_valid_i,
    output logic                   a_ready_o,
    output l2_tl_pkg::opcode_t     d_opcode_o,
    output l2_tl_pkg::cap_t        d_param_o,
    output l2_geom_pkg::source_t   d_source_o,
    output l2_geom_pkg::data_t     d_data_o,
    output logic                   d_valid_o,
    input  wire                    d_ready_i,
    output l2_geom_pkg::addr_t     mem_a_address_o,
    output logic                   mem_a_valid_o,
    input  wire                    mem_a_ready_i,
    input  l2_geom_pkg::data_t     mem_d_data_i,
    input  wire                    mem_d_valid_i,
    output logic                   mem_d_ready_o
);

    import l2_geom_pkg::*;

    set_t       set;
    tag_t       tag;
    way_mask_t  dir_we;
    core_mask_t dir_sharers;
    logic       dir_owner_valid;
    core_id_t   dir_owner_id;

    // Per-way lookup results
    way_mask_t                way_valid;
    way_mask_t                way_match;
    core_mask_t [N_WAYS-1:0]  way_sharers;
    way_mask_t                way_owner_valid;
    core_id_t [N_WAYS-1:0]    way_owner_id;

    logic       hit;
    way_t       hit_way;
    core_mask_t hit_sharers;
    logic       hit_owner_valid;
    core_id_t   hit_owner_id;
    way_t       victim_way;
    logic       touch;
    way_t       touch_way;

    way_t  data_way;
    beat_t data_beat;
    logic  data_we;
    data_t data_wdata;
    data_t data_rdata;

    l2_ctrl u_ctrl (
        .clk_i, .rst_ni,
        .a_opcode_i, .a_param_i, .a_source_i, .a_address_i, .a_valid_i, .a_ready_o,
        .d_opcode_o, .d_param_o, .d_source_o, .d_data_o, .d_valid_o, .d_ready_i,
        .mem_a_address_o, .mem_a_valid_o, .mem_a_ready_i,
        .mem_d_data_i, .mem_d_valid_i, .mem_d_ready_o,
        .set_o             (set),
        .tag_o             (tag),
        .hit_i             (hit),
        .hit_way_i         (hit_way),
        .hit_sharers_i     (hit_sharers),
        .hit_owner_valid_i (hit_owner_valid),
        .hit_owner_id_i    (hit_owner_id),
        .victim_way_i      (victim_way),
        .dir_we_o          (dir_we),
        .dir_sharers_o     (dir_sharers),
        .dir_owner_valid_o (dir_owner_valid),
        .dir_owner_id_o    (dir_owner_id),
        .touch_o           (touch),
        .touch_way_o       (touch_way),
        .data_way_o        (data_way),
        .data_beat_o       (data_beat),
        .data_we_o         (data_we),
        .data_wdata_o      (data_wdata),
        .data_rdata_i      (data_rdata)
    );

    for (genvar w = 0; w < N_WAYS; w++) begin : g_way
        l2_way_match u_way (
            .clk_i, .rst_ni,
            .set_i            (set),
            .tag_i            (tag),
            .we_i             (dir_we[w]),
            .wr_sharers_i     (dir_sharers),
            .wr_owner_valid_i (dir_owner_valid),
            .wr_owner_id_i    (dir_owner_id),
            .valid_o          (way_valid[w]),
            .match_o          (way_match[w]),
            .sharers_o        (way_sharers[w]),
            .owner_valid_o    (way_owner_valid[w]),
            .owner_id_o       (way_owner_id[w])
        );
    end

    l2_hit_select u_hit_select (
        .clk_i, .rst_ni,
        .set_i             (set),
        .valid_i           (way_valid),
        .match_i           (way_match),
        .sharers_i         (way_sharers),
        .owner_valid_i     (way_owner_valid),
        .owner_id_i        (way_owner_id),
        .touch_i           (touch),
        .touch_way_i       (touch_way),
        .hit_o             (hit),
        .hit_way_o         (hit_way),
        .hit_sharers_o     (hit_sharers),
        .hit_owner_valid_o (hit_owner_valid),
        .hit_owner_id_o    (hit_owner_id),
        .victim_way_o      (victim_way)
    );

    l2_data_array u_data (
        .clk_i,
        .way_i   (data_way),
        .set_i   (set),
        .beat_i  (data_beat),
        .we_i    (data_we),
        .wdata_i (data_wdata),
        .rdata_o (data_rdata)
    );

endmodule

`default_nettype wire

/* test/l2_checker.sv */
`default_nettype none

module l2_checker (
    input  wire                    clk_i,
    input  wire                    rst_ni,
    input  wire                    a_ready_o,
    input  l2_tl_pkg::opcode_t     d_opcode_o,
    input  l2_tl_pkg::cap_t        d_param_o,
    input  l2_geom_pkg::source_t   d_source_o,
    input  l2_geom_pkg::data_t     d_data_o,
    input  wire                    d_valid_o,
    input  wire                    d_ready_i,
    input  l2_geom_pkg::addr_t     mem_a_address_o,
    input  wire                    mem_a_valid_o,
    input  wire                    mem_a_ready_i,
    input  wire                    mem_d_ready_o
);

    int fail_count = 0;  // Failed assertions so far

    // Grant beat held while the core stalls
    property d_hold_p;
        @(posedge clk_i) disable iff (!rst_ni)
        (d_valid_o && !d_ready_i) |=> (d_valid_o && $stable(d_opcode_o) && $stable(d_param_o)
            && $stable(d_source_o) && $stable(d_data_o));
    endproperty

    property mem_a_hold_p;
        @(posedge clk_i) disable iff (!rst_ni)
        (mem_a_valid_o && !mem_a_ready_i) |=> (mem_a_valid_o && $stable(mem_a_address_o));
    endproperty

    // Controller is busy for the whole grant
    property a_d_exclusive_p;
        @(posedge clk_i) disable iff (!rst_ni)
        !(a_ready_o && d_valid_o);
    endproperty

    property reset_quiet_p;
        @(posedge clk_i)
        $rose(rst_ni) |-> (!d_valid_o && !mem_a_valid_o && !mem_d_ready_o);
    endproperty

    d_hold_a: assert property (d_hold_p)
        else begin
            $error("D outputs changed under back-pressure");
            fail_count++;
        end

    mem_a_hold_a: assert property (mem_a_hold_p)
        else begin
            $error("Memory Get dropped or changed before it was accepted");
            fail_count++;
        end

    a_d_exclusive_a: assert property (a_d_exclusive_p)
        else begin
            $error("A ready and D valid are high together");
            fail_count++;
        end

    reset_quiet_a: assert property (reset_quiet_p)
        else begin
            $error("A valid output is high in the first cycle after reset");
            fail_count++;
        end

endmodule

bind l2_top l2_checker u_checker (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .a_ready_o       (a_ready_o),
    .d_opcode_o      (d_opcode_o),
    .d_param_o       (d_param_o),
    .d_source_o      (d_source_o),
    .d_data_o        (d_data_o),
    .d_valid_o       (d_valid_o),
    .d_ready_i       (d_ready_i),
    .mem_a_address_o (mem_a_address_o),
    .mem_a_valid_o   (mem_a_valid_o),
    .mem_a_ready_i   (mem_a_ready_i),
    .mem_d_ready_o   (mem_d_ready_o)
);

`default_nettype wire

/* test/l2_tb.sv */
`default_nettype none

module l2_tb;

    import l2_geom_pkg::*;
    import l2_tl_pkg::*;

    localparam int WAIT_LIMIT = 400;  // Cycles per wait loop

    logic    clk_i;
    logic    rst_ni;
    opcode_t a_opcode_i;
    param_t  a_param_i;
    source_t a_source_i;
    addr_t   a_address_i;
    logic    a_valid_i;
    logic    a_ready_o;
    opcode_t d_opcode_o;
    cap_t    d_param_o;
    source_t d_source_o;
    data_t   d_data_o;
    logic    d_valid_o;
    logic    d_ready_i = 1'b0;
    addr_t   mem_a_address_o;
    logic    mem_a_valid_o;
    logic    mem_a_ready_i = 1'b0;
    data_t   mem_d_data_i = '0;
    logic    mem_d_valid_i = 1'b0;
    logic    mem_d_ready_o;

    logic [31:0] seed = 32'hd1c5;
    logic        throttle = 1'b0;  // Random stalls on D and memory
    logic        timed_out;
    int          errors;
    int          tests_ok;
    int          tests_bad;

    // Memory model
    addr_t fill_addr = '0;
    int    fill_beat = 0;
    logic  filling = 1'b0;
    int    get_count = 0;
    addr_t get_addr = '0;

    // What the current request should see on D
    opcode_t exp_opcode;
    cap_t    exp_param;
    source_t exp_source;
    addr_t   exp_line;
    int      beat_count;

    l2_top uut (.*);

    always #10 clk_i = ~clk_i;

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic addr_t make_addr(input int tag_no, input int set_no);
        return (addr_t'(tag_no) << 20) | (addr_t'(set_no) << OFFSET_W);
    endfunction

    task automatic report_value(input string name, input logic [63:0] got,
                                input logic [63:0] want);
        $display("ERROR %s: got %h, expected %h", name, got, want);
        errors++;
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        timed_out = 1'b1;
    endtask

    // Memory responder and ready throttling
    // Beat k of line A is A xor k
    always @(posedge clk_i) begin
        logic [31:0] r;
        r = next_rand();
        if (!rst_ni) begin
            filling   = 1'b0;
            fill_beat = 0;
        end else if (mem_a_valid_o && mem_a_ready_i) begin
            fill_addr = mem_a_address_o;
            fill_beat = 0;
            filling   = 1'b1;
            get_count <= get_count + 1;
            get_addr  <= mem_a_address_o;
        end else if (mem_d_valid_i && mem_d_ready_o) begin
            fill_beat = fill_beat + 1;
            filling   = (fill_beat < BEATS);
        end
        d_ready_i     <= !throttle || r[20];
        mem_a_ready_i <= !throttle || (r[22] && r[23]);  // Mostly stalled
        mem_d_valid_i <= filling && (!throttle || r[25]);
        mem_d_data_i  <= fill_addr ^ data_t'(fill_beat);
    end

    // Each completed D beat is checked as it happens
    always @(posedge clk_i) begin
        if (rst_ni && d_valid_o && d_ready_i) begin
            assert (d_opcode_o == exp_opcode)
                else report_value("d_opcode_o", 64'(d_opcode_o), 64'(exp_opcode));
            assert (d_param_o == exp_param)
                else report_value("d_param_o", 64'(d_param_o), 64'(exp_param));
            assert (d_source_o == exp_source)
                else report_value("d_source_o", 64'(d_source_o), 64'(exp_source));
            if (exp_opcode == D_GRANT_DATA) begin
                assert (d_data_o == (exp_line ^ data_t'(beat_count)))
                    else report_value("d_data_o", d_data_o, exp_line ^ data_t'(beat_count));
            end
            beat_count++;
        end
    end

    task automatic run_acquire(input opcode_t op, input param_t prm, input addr_t addr,
                               input int want_gets, input logic want_fast);
        int cnt;
        int lat;
        int gets_before;
        if (timed_out) return;
        exp_opcode  = (op == A_ACQUIRE_BLOCK) ? D_GRANT_DATA : D_GRANT;
        exp_param   = (op == A_ACQUIRE_BLOCK && prm == GROW_NTOB) ? CAP_TOB : CAP_TOT;
        exp_source  = source_t'(next_rand() >> 7);
        exp_line    = addr & ~addr_t'(64'h3f);
        beat_count  = 0;
        gets_before = get_count;
        @(posedge clk_i);
        a_opcode_i  <= op;
        a_param_i   <= prm;
        a_source_i  <= exp_source;
        a_address_i <= addr;
        a_valid_i   <= 1'b1;
        cnt = 0;
        do begin
            @(posedge clk_i);
            cnt++;
        end while (!(a_valid_i && a_ready_o) && cnt < WAIT_LIMIT);
        a_valid_i <= 1'b0;
        if (cnt >= WAIT_LIMIT) begin
            report_timeout("the request to be accepted");
            return;
        end
        lat = 0;  // Counted from the accept edge
        do begin
            @(posedge clk_i);
            lat++;
        end while (!d_valid_o && lat < WAIT_LIMIT);
        if (!d_valid_o) begin
            report_timeout("the first D beat");
            return;
        end
        if (want_fast) begin
            assert (lat == 2) else report_value("d_valid_o latency", 64'(lat), 64'(2));
        end
        cnt = 0;
        do begin
            @(posedge clk_i);
            cnt++;
        end while (!a_ready_o && cnt < WAIT_LIMIT);
        if (!a_ready_o) begin
            report_timeout("the controller to return to idle");
            return;
        end
        assert (beat_count == ((op == A_ACQUIRE_BLOCK) ? BEATS : 1))
            else report_value("D beat count", 64'(beat_count),
                              64'((op == A_ACQUIRE_BLOCK) ? BEATS : 1));
        assert (get_count - gets_before == want_gets)
            else report_value("Get count", 64'(get_count - gets_before), 64'(want_gets));
        if (want_gets > 0) begin
            assert (get_addr == exp_line)
                else report_value("mem_a_address_o", get_addr, exp_line);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (errors == errors_before && !timed_out) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: failed", name);
        end
    endtask

    initial begin
        int mark;
        clk_i       = 1'b0;
        rst_ni      = 1'b0;
        a_valid_i   = 1'b0;
        a_opcode_i  = A_ACQUIRE_BLOCK;
        a_param_i   = GROW_NTOB;
        a_source_i  = '0;
        a_address_i = '0;
        timed_out   = 1'b0;
        errors      = 0;
        tests_ok    = 0;
        tests_bad   = 0;
        repeat (10) @(posedge clk_i);
        rst_ni <= 1'b1;
        repeat (2) @(posedge clk_i);

        mark = errors;
        run_acquire(A_ACQUIRE_BLOCK, GROW_NTOB, make_addr(7, 3) + 64'h8, 1, 1'b0);
        finish_test("miss", mark);

        mark = errors;
        run_acquire(A_ACQUIRE_BLOCK, GROW_NTOB, make_addr(7, 3), 0, 1'b1);
        finish_test("hit", mark);

        mark = errors;
        run_acquire(A_ACQUIRE_PERM, GROW_BTOT, make_addr(7, 3), 0, 1'b1);
        run_acquire(A_ACQUIRE_BLOCK, GROW_NTOT, make_addr(9, 3), 1, 1'b0);
        finish_test("permission", mark);

        // Fill set 5 in order, then evict the oldest line
        mark = errors;
        for (int n = 1; n <= 5; n++) begin
            run_acquire(A_ACQUIRE_BLOCK, GROW_NTOB, make_addr(n, 5), 1, 1'b0);
        end
        run_acquire(A_ACQUIRE_BLOCK, GROW_NTOB, make_addr(1, 5), 1, 1'b0);
        run_acquire(A_ACQUIRE_BLOCK, GROW_NTOB, make_addr(4, 5), 0, 1'b1);
        run_acquire(A_ACQUIRE_BLOCK, GROW_NTOB, make_addr(5, 5), 0, 1'b1);  // Third line went
        finish_test("replacement", mark);

        mark = errors;
        throttle <= 1'b1;
        run_acquire(A_ACQUIRE_BLOCK, GROW_NTOB, make_addr(12, 7) + 64'h18, 1, 1'b0);
        run_acquire(A_ACQUIRE_BLOCK, GROW_NTOT, make_addr(12, 7), 0, 1'b1);
        run_acquire(A_ACQUIRE_PERM, GROW_NTOT, make_addr(12, 7), 0, 1'b1);
        throttle <= 1'b0;
        finish_test("back-pressure", mark);

        $display("tests passed %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests_ok, tests_bad, errors, uut.u_checker.fail_count);
        if (errors == 0 && tests_bad == 0 && !timed_out && uut.u_checker.fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
hdl/l2_geom_pkg.sv
hdl/l2_tl_pkg.sv
hdl/l2_way_match.sv
hdl/l2_hit_select.sv
hdl/l2_data_array.sv
hdl/l2_ctrl.sv
hdl/l2_top.sv
test/l2_checker.sv
test/l2_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= l2_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Verification passed
VFLAGS    ?= --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
